/* source/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// architectural register count, register 0 is hardwired to zero
`define CPU_NUM_REGS 32

// instruction word-address width, also the width of the pc
`define CPU_IMEM_AW 8

// data memory words, addresses wrap modulo this depth
`define CPU_DMEM_DEPTH 64

`endif

/* source/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [5:0] {
		NOP  = 6'd0,
		ALU  = 6'd1,
		ADDI = 6'd2,
		LW   = 6'd3,
		SW   = 6'd4,
		BEQZ = 6'd5
	} opcode_t;

	// carried in sub_op_base, bits 4..0 of a register ALU instruction
	typedef enum logic [4:0] {
		ADD = 5'd0,
		SUB = 5'd1,
		AND = 5'd2,
		OR  = 5'd3,
		XOR = 5'd4,
		SLT = 5'd5
	} alu_op_t;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_REG    = 2'd0,
		FWD_EX_MEM = 2'd1,
		FWD_MEM_WB = 2'd2
	} fwd_sel_t;

	typedef struct packed {
		logic                    valid;
		logic [`CPU_IMEM_AW-1:0] pc;
		instr_t                  instr;
	} if_id_t;

	typedef struct packed {
		logic                    valid;
		logic [`CPU_IMEM_AW-1:0] pc;
		opcode_t                 opcode;
		alu_op_t                 alu_op;
		word_t                   ra_data;
		word_t                   rb_data;
		reg_addr_t               ra_addr;
		reg_addr_t               rb_addr;
		word_t                   imm;
		logic                    use_imm;
		logic                    dm_read;
		logic                    dm_write;
		logic                    reg_write;
		reg_addr_t               wr_addr;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		word_t     result; // alu result, memory address for lw and sw
		logic      overflow;
		word_t     store_data;
		logic      dm_read;
		logic      dm_write;
		logic      reg_write;
		reg_addr_t wr_addr;
	} ex_mem_t;

	// valid here means a real register write, never to register 0
	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		word_t     data;
		logic      overflow;
	} wb_t;

endpackage

/* source/pipe_wall.sv */
`timescale 1ns/1ns

module pipe_wall #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// flush beats hold, an all-zero payload is a bubble
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

/* source/decoder.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decoder (
	input  cpu_pkg::instr_t          instr,
	input  logic [`CPU_IMEM_AW-1:0]  pc,
	output cpu_pkg::reg_addr_t       ra_addr,
	output cpu_pkg::reg_addr_t       rb_addr,
	output cpu_pkg::id_ex_t          ctrl
);
	import cpu_pkg::*;

	reg_addr_t rt;
	reg_addr_t ra;
	reg_addr_t rb;
	word_t     imm_ext;

	assign rt = instr[25:21];
	assign ra = instr[20:16];
	assign rb = instr[15:11];
	assign imm_ext = {{18{instr[13]}}, instr[13:0]};

	// register data fields stay zero, the core fills them in
	always_comb begin
		ctrl = '0;
		ctrl.pc = pc;
		ctrl.imm = imm_ext;
		ctrl.alu_op = ADD; // address and immediate math
		case (instr[31:26])
			ALU: begin
				ctrl.opcode = ALU;
				ctrl.alu_op = alu_op_t'(instr[4:0]);
				ctrl.ra_addr = ra;
				ctrl.rb_addr = rb;
				ctrl.reg_write = (rt != '0);
				ctrl.wr_addr = rt;
			end
			ADDI: begin
				ctrl.opcode = ADDI;
				ctrl.ra_addr = ra;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = (rt != '0);
				ctrl.wr_addr = rt;
			end
			LW: begin
				ctrl.opcode = LW;
				ctrl.ra_addr = ra;
				ctrl.use_imm = 1'b1;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = (rt != '0);
				ctrl.wr_addr = rt;
			end
			SW: begin
				ctrl.opcode = SW;
				ctrl.ra_addr = ra;
				ctrl.rb_addr = rt; // store data comes through the b port
				ctrl.use_imm = 1'b1;
				ctrl.dm_write = 1'b1;
			end
			BEQZ: begin
				ctrl.opcode = BEQZ;
				ctrl.ra_addr = ra;
			end
			default: begin
				ctrl.opcode = NOP; // unknown opcodes behave as nop
			end
		endcase
	end

	assign ra_addr = ctrl.ra_addr;
	assign rb_addr = ctrl.rb_addr;

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file (
	input  logic               clock,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::word_t     ra_data,
	output cpu_pkg::word_t     rb_data,
	input  cpu_pkg::wb_t       wr
);
	import cpu_pkg::*;

	word_t regs [1:`CPU_NUM_REGS-1]; // no storage for register 0

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// same-cycle write passes straight through to the readers
	assign ra_data = (ra_addr == '0) ? '0 :
		(wr.valid && wr.addr == ra_addr) ? wr.data : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 :
		(wr.valid && wr.addr == rb_addr) ? wr.data : regs[rb_addr];

endmodule

/* source/alu.sv */
`timescale 1ns/1ns

module alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result,
	output logic             overflow,
	output logic             a_zero
);
	import cpu_pkg::*;

	word_t sum;
	word_t diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (op)
			ADD: begin
				result = sum;
				overflow = (a[31] == b[31]) && (sum[31] != a[31]); // same signs in, other sign out
			end
			SUB: begin
				result = diff;
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			AND: result = a & b;
			OR:  result = a | b;
			XOR: result = a ^ b;
			SLT: result = {31'b0, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	assign a_zero = (a == '0); // beqz condition

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
	input  cpu_pkg::if_id_t    if_id,
	input  cpu_pkg::id_ex_t    id_ex,
	input  cpu_pkg::ex_mem_t   ex_mem,
	input  cpu_pkg::wb_t       mem_wb,
	input  logic               branch_taken,
	output cpu_pkg::fwd_sel_t  fwd_a,
	output cpu_pkg::fwd_sel_t  fwd_b,
	output logic               stall,
	output logic               branch_flush
);
	import cpu_pkg::*;

	reg_addr_t src_a;
	reg_addr_t src_b;
	logic      ex_fwd_ok;
	logic      wb_fwd_ok;
	logic      load_use;

	// sources of the instruction waiting in decode
	always_comb begin
		src_a = '0;
		src_b = '0;
		case (if_id.instr[31:26])
			ALU: begin
				src_a = if_id.instr[20:16];
				src_b = if_id.instr[15:11];
			end
			ADDI, LW, BEQZ: begin
				src_a = if_id.instr[20:16];
			end
			SW: begin
				src_a = if_id.instr[20:16];
				src_b = if_id.instr[25:21];
			end
			default: ;
		endcase
	end

	// load data is not ready until mem_wb
	assign ex_fwd_ok = ex_mem.valid && ex_mem.reg_write && !ex_mem.dm_read &&
		(ex_mem.wr_addr != '0);
	assign wb_fwd_ok = mem_wb.valid && (mem_wb.addr != '0);

	assign fwd_a = (ex_fwd_ok && ex_mem.wr_addr == id_ex.ra_addr) ? FWD_EX_MEM :
		(wb_fwd_ok && mem_wb.addr == id_ex.ra_addr) ? FWD_MEM_WB : FWD_REG;
	assign fwd_b = (ex_fwd_ok && ex_mem.wr_addr == id_ex.rb_addr) ? FWD_EX_MEM :
		(wb_fwd_ok && mem_wb.addr == id_ex.rb_addr) ? FWD_MEM_WB : FWD_REG;

	assign load_use = if_id.valid && id_ex.valid && id_ex.dm_read && id_ex.reg_write &&
		(id_ex.wr_addr != '0) && (id_ex.wr_addr == src_a || id_ex.wr_addr == src_b);

	assign branch_flush = branch_taken && id_ex.valid && (id_ex.opcode == BEQZ);
	assign stall = load_use && !branch_flush; // a taken branch discards the waiting use

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module data_mem (
	input  logic             clock,
	input  logic             arst_n,
	input  cpu_pkg::ex_mem_t access,
	output cpu_pkg::word_t   rdata
);
	import cpu_pkg::*;

	localparam int DM_AW = $clog2(`CPU_DMEM_DEPTH);

	word_t            mem [`CPU_DMEM_DEPTH];
	logic [DM_AW-1:0] index;

	assign index = access.result[DM_AW-1:0]; // wraps modulo depth

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (access.valid && access.dm_write) begin
			mem[index] <= access.store_data;
		end
	end

	assign rdata = mem[index];

endmodule

/* source/cpu_core.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_core (
	input  logic                     clock,
	input  logic                     arst_n,
	output logic [`CPU_IMEM_AW-1:0]  imem_addr,
	input  cpu_pkg::instr_t          imem_data,
	output cpu_pkg::wb_t             wb
);
	import cpu_pkg::*;

	logic [`CPU_IMEM_AW-1:0] pc;
	logic [`CPU_IMEM_AW-1:0] branch_target;

	if_id_t    if_id_d;
	if_id_t    if_id_q;
	id_ex_t    dec_ctrl;
	id_ex_t    id_ex_d;
	id_ex_t    id_ex_q;
	ex_mem_t   ex_mem_d;
	ex_mem_t   ex_mem_q;
	wb_t       mem_wb_d;
	wb_t       mem_wb_q;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	word_t     ra_data;
	word_t     rb_data;

	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	logic      stall;
	logic      branch_flush;

	word_t     op_a;
	word_t     op_b;
	word_t     alu_b;
	word_t     alu_result;
	logic      alu_overflow;
	logic      a_zero;
	word_t     dm_rdata;

	// fetch
	assign branch_target = id_ex_q.pc + 1'b1 + id_ex_q.imm[`CPU_IMEM_AW-1:0];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (branch_flush) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	assign imem_addr = pc;
	assign if_id_d = '{valid: 1'b1, pc: pc, instr: imem_data};

	pipe_wall #(.payload_t(if_id_t)) if_id_wall (
		.clock  (clock),
		.arst_n (arst_n),
		.hold   (stall),
		.flush  (branch_flush),
		.d      (if_id_d),
		.q      (if_id_q)
	);

	// decode
	decoder decoder_inst (
		.instr   (if_id_q.instr),
		.pc      (if_id_q.pc),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ctrl    (dec_ctrl)
	);

	reg_file reg_file_inst (
		.clock   (clock),
		.arst_n  (arst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr      (mem_wb_q)
	);

	always_comb begin
		id_ex_d = dec_ctrl;
		id_ex_d.valid = if_id_q.valid;
		id_ex_d.ra_data = ra_data;
		id_ex_d.rb_data = rb_data;
	end

	pipe_wall #(.payload_t(id_ex_t)) id_ex_wall (
		.clock  (clock),
		.arst_n (arst_n),
		.hold   (1'b0),
		.flush  (stall | branch_flush), // a stall leaves a bubble here
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	// execute
	always_comb begin
		case (fwd_a)
			FWD_EX_MEM: op_a = ex_mem_q.result;
			FWD_MEM_WB: op_a = mem_wb_q.data;
			default:    op_a = id_ex_q.ra_data;
		endcase
		case (fwd_b)
			FWD_EX_MEM: op_b = ex_mem_q.result;
			FWD_MEM_WB: op_b = mem_wb_q.data;
			default:    op_b = id_ex_q.rb_data;
		endcase
	end

	assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : op_b;

	alu alu_inst (
		.op       (id_ex_q.alu_op),
		.a        (op_a),
		.b        (alu_b),
		.result   (alu_result),
		.overflow (alu_overflow),
		.a_zero   (a_zero)
	);

	hazard_unit hazard_unit_inst (
		.if_id        (if_id_q),
		.id_ex        (id_ex_q),
		.ex_mem       (ex_mem_q),
		.mem_wb       (mem_wb_q),
		.branch_taken (a_zero), // qualified with beqz inside
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.stall        (stall),
		.branch_flush (branch_flush)
	);

	always_comb begin
		ex_mem_d.valid = id_ex_q.valid;
		ex_mem_d.result = alu_result;
		// address math never reports overflow
		ex_mem_d.overflow = alu_overflow && !(id_ex_q.dm_read || id_ex_q.dm_write);
		ex_mem_d.store_data = op_b;
		ex_mem_d.dm_read = id_ex_q.dm_read;
		ex_mem_d.dm_write = id_ex_q.dm_write;
		ex_mem_d.reg_write = id_ex_q.reg_write;
		ex_mem_d.wr_addr = id_ex_q.wr_addr;
	end

	pipe_wall #(.payload_t(ex_mem_t)) ex_mem_wall (
		.clock  (clock),
		.arst_n (arst_n),
		.hold   (1'b0),
		.flush  (1'b0),
		.d      (ex_mem_d),
		.q      (ex_mem_q)
	);

	// memory
	data_mem data_mem_inst (
		.clock  (clock),
		.arst_n (arst_n),
		.access (ex_mem_q),
		.rdata  (dm_rdata)
	);

	always_comb begin
		mem_wb_d.valid = ex_mem_q.valid && ex_mem_q.reg_write && (ex_mem_q.wr_addr != '0);
		mem_wb_d.addr = ex_mem_q.wr_addr;
		mem_wb_d.data = ex_mem_q.dm_read ? dm_rdata : ex_mem_q.result;
		mem_wb_d.overflow = ex_mem_q.overflow;
	end

	pipe_wall #(.payload_t(wb_t)) mem_wb_wall (
		.clock  (clock),
		.arst_n (arst_n),
		.hold   (1'b0),
		.flush  (1'b0),
		.d      (mem_wb_d),
		.q      (mem_wb_q)
	);

	assign wb = mem_wb_q; // also the register file write port

endmodule

/* tb/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int PROG_LEN = 64;
	localparam int PREAMBLE_LEN = 22;
	localparam int IMEM_WORDS = 1 << `CPU_IMEM_AW;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 3 + 40;

	logic                    clock;
	logic                    arst_n;
	logic [`CPU_IMEM_AW-1:0] imem_addr;
	instr_t                  imem_data;
	wb_t                     wb;

	instr_t      program_mem [IMEM_WORDS];
	wb_t         expected_q [$];
	reg_addr_t   recent_dest [3]; // last three destinations with the newest first
	logic [31:0] lcg_state;
	int          cycle_count;
	int          writes_seen;

	cpu_core cpu_core_inst (
		.clock     (clock),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb)
	);

	always #2 clock = ~clock;

	assign imem_data = program_mem[imem_addr]; // instruction memory answers in the same cycle

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int pick(int n);
		logic [31:0] r;
		r = next_random();
		return int'(r[31:16] % n); // upper bits since the low ones cycle quickly
	endfunction

	function automatic reg_addr_t pick_source();
		if (pick(2) == 0) begin
			return recent_dest[pick(3)];
		end
		return reg_addr_t'(pick(8));
	endfunction

	function automatic instr_t encode(opcode_t op, reg_addr_t rt, reg_addr_t ra,
		reg_addr_t rb, logic [13:0] low);
		instr_t instr;
		instr = {op, rt, ra, 16'b0};
		instr[15:11] = rb;
		instr[13:0] = instr[13:0] | low;
		return instr;
	endfunction

	function automatic logic out_of_range(longint value);
		return (value > 64'sd2147483647) || (value < -64'sd2147483648);
	endfunction

	task automatic build_program();
		int          kind;
		reg_addr_t   rt;
		reg_addr_t   ra;
		reg_addr_t   rb;
		logic [13:0] imm;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			program_mem[i] = '0;
		end
		// r1 doubles from -8192 down to the most negative word
		program_mem[0] = encode(ADDI, 5'd1, '0, '0, 14'h2000);
		for (int i = 1; i <= 18; i++) begin
			program_mem[i] = encode(ALU, 5'd1, 5'd1, 5'd1, 14'(ADD));
		end
		program_mem[19] = encode(ALU, 5'd2, 5'd1, 5'd1, 14'(ADD)); // wraps to zero
		program_mem[20] = encode(ALU, 5'd3, '0, 5'd1, 14'(SUB));
		program_mem[21] = encode(ADDI, 5'd4, 5'd1, '0, 14'h3fff); // minus one
		recent_dest[0] = 5'd4;
		recent_dest[1] = 5'd3;
		recent_dest[2] = 5'd2;
		for (int i = PREAMBLE_LEN; i < PROG_LEN; i++) begin
			kind = pick(10);
			rt = reg_addr_t'(pick(8));
			ra = pick_source();
			rb = pick_source();
			imm = 14'(next_random() >> 8);
			if (kind < 4) begin
				program_mem[i] = encode(ALU, rt, ra, rb, 14'(pick(6)));
			end else if (kind < 6) begin
				program_mem[i] = encode(ADDI, rt, ra, '0, imm);
			end else if (kind < 8) begin
				if (pick(2) == 0) begin
					ra = '0; // small absolute addresses so loads meet earlier stores
				end
				if (kind == 6) begin
					program_mem[i] = encode(LW, rt, ra, '0, 14'(pick(8)));
				end else begin
					program_mem[i] = encode(SW, pick_source(), ra, '0, 14'(pick(8)));
				end
			end else if (kind == 8) begin
				program_mem[i] = encode(BEQZ, '0, ra, '0, 14'(1 + pick(4)));
			end
			if (kind < 7) begin
				recent_dest[2] = recent_dest[1];
				recent_dest[1] = recent_dest[0];
				recent_dest[0] = rt;
			end
		end
	endtask

	// architectural model that runs one instruction at a time in program order
	task automatic run_model();
		word_t     regs [`CPU_NUM_REGS];
		word_t     dmem [`CPU_DMEM_DEPTH];
		int        pc;
		int        next_pc;
		instr_t    instr;
		reg_addr_t rt;
		word_t     a;
		word_t     b;
		word_t     imm;
		word_t     addr;
		word_t     result;
		longint    wide;
		logic      ovf;
		logic      writes;
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
			dmem[i] = '0;
		end
		pc = 0;
		while (pc < PROG_LEN) begin
			instr = program_mem[pc];
			rt = instr[25:21];
			a = regs[instr[20:16]];
			b = regs[instr[15:11]];
			imm = 32'($signed(instr[13:0]));
			addr = (a + imm) % `CPU_DMEM_DEPTH;
			next_pc = pc + 1;
			writes = 1'b0;
			ovf = 1'b0;
			result = '0;
			case (instr[31:26])
				ALU: begin
					writes = 1'b1;
					case (instr[4:0])
						ADD: wide = longint'($signed(a)) + longint'($signed(b));
						SUB: wide = longint'($signed(a)) - longint'($signed(b));
						AND: wide = longint'(a & b);
						OR:  wide = longint'(a | b);
						XOR: wide = longint'(a ^ b);
						default: wide = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					endcase
					result = word_t'(wide);
					ovf = (instr[4:0] == ADD || instr[4:0] == SUB) && out_of_range(wide);
				end
				ADDI: begin
					writes = 1'b1;
					wide = longint'($signed(a)) + longint'($signed(imm));
					result = word_t'(wide);
					ovf = out_of_range(wide);
				end
				LW: begin
					writes = 1'b1;
					result = dmem[addr];
				end
				SW: dmem[addr] = regs[rt];
				BEQZ: begin
					if (a == '0) begin
						next_pc = pc + 1 + int'($signed(imm));
					end
				end
				default: ;
			endcase
			if (writes && rt != '0) begin
				regs[rt] = result;
				expected_q.push_back('{valid: 1'b1, addr: rt, data: result, overflow: ovf});
			end
			pc = next_pc;
		end
	endtask

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_writeback();
		wb_t want;
		assert (expected_q.size() > 0) else begin
			$display("write-back to r%0d appeared after every expected write had retired",
				wb.addr);
			stop_with_failure();
		end
		want = expected_q.pop_front();
		assert (wb.addr == want.addr) else begin
			$display("FAIL wb.addr expected 0x%0h got 0x%0h", want.addr, wb.addr);
			stop_with_failure();
		end
		assert (wb.data == want.data) else begin
			$display("FAIL wb.data expected 0x%08h got 0x%08h", want.data, wb.data);
			stop_with_failure();
		end
		assert (wb.overflow == want.overflow) else begin
			$display("FAIL wb.overflow expected 0x%0h got 0x%0h", want.overflow, wb.overflow);
			stop_with_failure();
		end
		writes_seen++;
	endtask

	// outputs are sampled half a cycle after the rising edge
	always @(negedge clock) begin
		if (!arst_n) begin
			assert (!wb.valid) else begin
				$display("wb.valid was high while reset was asserted");
				stop_with_failure();
			end
			assert (imem_addr == '0) else begin
				$display("FAIL imem_addr expected 0x0 got 0x%0h", imem_addr);
				stop_with_failure();
			end
		end else begin
			cycle_count++;
			assert (cycle_count <= TIMEOUT_CYCLES) else begin
				$display("timeout after %0d cycles, %0d expected write-backs never arrived",
					cycle_count, expected_q.size());
				stop_with_failure();
			end
			if (wb.valid) begin
				check_writeback();
			end
		end
	end

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		lcg_state = 32'd93;
		cycle_count = 0;
		writes_seen = 0;
		build_program();
		run_model();
		repeat (10) @(posedge clock);
		@(negedge clock);
		arst_n <= 1'b1;
		while (expected_q.size() > 0) begin
			@(posedge clock);
		end
		repeat (10) @(posedge clock); // nothing more may retire during these nops
		$display("%0d write-backs checked in %0d cycles", writes_seen, cycle_count);
		$display("All tests passed");
		$finish;
	end

endmodule

/* mini_cpu.f */
+incdir+source
source/cpu_pkg.sv
source/pipe_wall.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/hazard_unit.sv
source/data_mem.sv
source/cpu_core.sv
tb/cpu_tb.sv

/* Bender.yml */
package:
  name: mini_cpu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/pipe_wall.sv
      - source/decoder.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/hazard_unit.sv
      - source/data_mem.sv
      - source/cpu_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tb/cpu_tb.sv
